//--- src/stream_pkg.sv
package stream_pkg;

  // ====================
  // datapath widths
  localparam int PIXEL_W = 16;    // rgb565 camera word
  localparam int BYTE_W  = 8;     // usb data byte
  localparam int LEN_W   = 12;    // txdat_len field of the device controller

  // ====================
  // fifo geometry
  localparam int FIFO_BYTES = 1024;                  // total byte capacity
  localparam int CNT_W      = 11;                    // 0..1024 inclusive
  localparam int ADDR_W     = $clog2(FIFO_BYTES);    // byte address
  localparam logic [CNT_W-1:0] FIFO_DEPTH = CNT_W'(FIFO_BYTES);
  localparam logic [CNT_W-1:0] WORD_BYTES = CNT_W'(PIXEL_W / BYTE_W);  // bytes per pixel

  // ====================
  // bulk packet
  localparam int PKT_BYTES = 512;                    // bytes per packet, also start threshold
  localparam int PKT_IDX_W = $clog2(PKT_BYTES);      // byte index inside a packet
  localparam logic [CNT_W-1:0]     PKT_THRESH = CNT_W'(PKT_BYTES);
  localparam logic [LEN_W-1:0]     PKT_LEN    = LEN_W'(PKT_BYTES);
  localparam logic [PKT_IDX_W-1:0] PKT_LAST   = PKT_IDX_W'(PKT_BYTES - 1);

  // packet sender states
  typedef enum logic {
    TX_IDLE,  // corked until a full packet is buffered
    TX_SEND   // packet open, host pops bytes
  } tx_state_e;

endpackage

//--- src/status_pkg.sv
package status_pkg;

  // ====================
  // counters
  localparam int FRAME_CNT_W = 16;  // pixels per frame and drop total

  // ====================
  // board leds
  localparam int LED_W = 4;              // led bus width
  localparam logic LED_ON  = 1'b0;       // leds sink current, lit when low
  localparam logic LED_OFF = ~LED_ON;

  // bit positions on the led bus
  localparam int LED_ONLINE = 0;  // usb enumerated
  localparam int LED_OVF    = 1;  // sticky overflow
  localparam int LED_SPARE  = 2;  // unused, held dark
  localparam int LED_RUN    = 3;  // out of reset

endpackage

//--- src/pixel_decode.sv
`timescale 1ns/1ps

module pixel_decode (
  input  logic                         ulpi_clk,
  input  logic                         I_rst_n,
  input  logic                         cam_vsync_i,        // frame sync level
  input  logic                         cam_de_i,           // pixel valid
  input  logic [stream_pkg::PIXEL_W-1:0] cam_data_i,       // camera byte order
  input  logic                         fifo_almost_full_i, // no room for another pixel
  output logic                         wr_en_o,            // fifo word write
  output logic [stream_pkg::PIXEL_W-1:0] wr_data_o,        // r,g,b packed
  output logic                         frame_start_o,      // one cycle per vsync rise
  output logic                         pixel_written_o,    // pixel went into fifo
  output logic                         pixel_dropped_o     // pixel lost to a full fifo
);

  logic vsync_q;  // previous vsync sample
  logic accept;   // pixel present and fifo has room

  assign accept = cam_de_i & ~fifo_almost_full_i;

  // ====================
  // control strobes
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      vsync_q         <= 1'b0;
      frame_start_o   <= 1'b0;
      wr_en_o         <= 1'b0;
      pixel_written_o <= 1'b0;
      pixel_dropped_o <= 1'b0;
    end else begin
      vsync_q         <= cam_vsync_i;
      frame_start_o   <= cam_vsync_i & ~vsync_q;      // rising edge only
      wr_en_o         <= accept;
      pixel_written_o <= accept;                      // status sees same event as fifo
      pixel_dropped_o <= cam_de_i & fifo_almost_full_i;
    end
  end

  // ====================
  // colour reorder
  // camera puts red in the low field and blue on top, usb side wants r,g,b msb first
  always_ff @(posedge ulpi_clk) begin
    if (cam_de_i) begin
      wr_data_o <= {cam_data_i[4:0],     // red
                    cam_data_i[10:5],    // green
                    cam_data_i[15:11]};  // blue
    end
  end

endmodule

//--- src/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
  input  logic                           ulpi_clk,
  input  logic                           I_rst_n,
  input  logic                           wr_en_i,        // one pixel word in
  input  logic [stream_pkg::PIXEL_W-1:0] wr_data_i,
  input  logic                           rd_en_i,        // one byte out
  output logic                           almost_full_o,  // refuse the next pixel
  output logic [stream_pkg::CNT_W-1:0]   byte_count_o,   // bytes buffered
  output logic [stream_pkg::BYTE_W-1:0]  head_byte_o     // fall-through head
);

  // ====================
  // storage
  // two banks of half depth, even byte addresses hold the high byte of each word
  logic [stream_pkg::BYTE_W-1:0] hi_mem [stream_pkg::FIFO_BYTES/2];  // even addresses
  logic [stream_pkg::BYTE_W-1:0] lo_mem [stream_pkg::FIFO_BYTES/2];  // odd addresses

  logic [stream_pkg::ADDR_W-2:0] wr_word_q;   // word write pointer
  logic [stream_pkg::ADDR_W-1:0] rd_ptr_q;    // byte read pointer
  logic [stream_pkg::CNT_W-1:0]  byte_count_q;
  logic [stream_pkg::CNT_W-1:0]  in_flight;   // bytes landing on this edge
  logic [stream_pkg::CNT_W-1:0]  free_bytes;  // room left once they land
  logic [stream_pkg::CNT_W-1:0]  count_next;
  logic                          rd_ok;       // read with data present

  assign rd_ok = rd_en_i & (byte_count_q != '0);

  // ====================
  // flags
  assign in_flight  = wr_en_i ? stream_pkg::WORD_BYTES : '0;
  assign free_bytes = stream_pkg::FIFO_DEPTH - byte_count_q - in_flight;

  // decode decides one cycle before its write lands, so the word in flight is counted
  // and the pixel being decided must still leave more than one byte free
  assign almost_full_o = free_bytes < (stream_pkg::WORD_BYTES + stream_pkg::WORD_BYTES);

  assign byte_count_o = byte_count_q;

  // ====================
  // write side
  always_ff @(posedge ulpi_clk) begin
    if (wr_en_i) begin
      hi_mem[wr_word_q] <= wr_data_i[stream_pkg::PIXEL_W-1:stream_pkg::BYTE_W];  // goes out first
      lo_mem[wr_word_q] <= wr_data_i[stream_pkg::BYTE_W-1:0];
    end
  end

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_word_q <= '0;
    end else if (wr_en_i) begin
      wr_word_q <= wr_word_q + 1'b1;  // wraps with the ring
    end
  end

  // ====================
  // read side
  // async read so the byte is valid in the pop cycle
  always_comb begin
    if (rd_ptr_q[0]) begin
      head_byte_o = lo_mem[rd_ptr_q[stream_pkg::ADDR_W-1:1]];
    end else begin
      head_byte_o = hi_mem[rd_ptr_q[stream_pkg::ADDR_W-1:1]];
    end
  end

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      rd_ptr_q <= '0;
    end else if (rd_ok) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;  // alternates banks
    end
  end

  // ====================
  // occupancy
  // +2 per word, -1 per byte, both may happen in one cycle
  assign count_next = byte_count_q
                    + in_flight
                    - {{(stream_pkg::CNT_W-1){1'b0}}, rd_ok};

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      byte_count_q <= '0;
    end else begin
      byte_count_q <= count_next;
    end
  end

endmodule

//--- src/packet_tx.sv
`timescale 1ns/1ps

module packet_tx (
  input  logic                          ulpi_clk,
  input  logic                          I_rst_n,
  input  logic [stream_pkg::CNT_W-1:0]  byte_count_i,  // fifo occupancy
  input  logic [stream_pkg::BYTE_W-1:0] head_byte_i,   // fifo head, fall-through
  input  logic                          txpop_i,       // controller takes a byte
  output logic                          rd_en_o,       // fifo pop
  output logic [stream_pkg::BYTE_W-1:0] txdat_o,
  output logic                          txval_o,       // packet in progress
  output logic                          txcork_o,      // nothing to send yet
  output logic [stream_pkg::LEN_W-1:0]  txdat_len_o,   // fixed bulk length
  output logic                          pkt_done_o     // last byte of packet
);

  stream_pkg::tx_state_e state_q;
  stream_pkg::tx_state_e state_d;

  logic [stream_pkg::PKT_IDX_W-1:0] byte_idx_q;  // bytes popped in this packet
  logic                             pkt_ready;   // a full packet is buffered
  logic                             sending;
  logic                             last_byte;

  assign pkt_ready = byte_count_i >= stream_pkg::PKT_THRESH;
  assign sending   = state_q == stream_pkg::TX_SEND;
  assign last_byte = byte_idx_q == stream_pkg::PKT_LAST;

  // ====================
  // controller side
  assign txdat_o     = head_byte_i;           // byte valid with the pop
  assign txdat_len_o = stream_pkg::PKT_LEN;   // always a full packet
  assign txval_o     = sending;
  assign rd_en_o     = txpop_i & sending;     // pops while idle go nowhere
  assign pkt_done_o  = rd_en_o & last_byte;   // same cycle as the 512th pop

  // uncorked as soon as idle sees a packet's worth, and for the whole packet after
  always_comb begin
    if (sending) begin
      txcork_o = 1'b0;
    end else begin
      txcork_o = ~pkt_ready;
    end
  end

  // ====================
  // sender fsm
  always_comb begin
    state_d = state_q;
    case (state_q)
      stream_pkg::TX_IDLE: begin
        if (pkt_ready) begin
          state_d = stream_pkg::TX_SEND;  // open packet next edge
        end
      end
      stream_pkg::TX_SEND: begin
        if (pkt_done_o) begin
          state_d = stream_pkg::TX_IDLE;  // re-evaluate threshold
        end
      end
      default: state_d = stream_pkg::TX_IDLE;
    endcase
  end

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state_q <= stream_pkg::TX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // byte index, wraps to zero right after the last byte
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      byte_idx_q <= '0;
    end else if (!sending) begin
      byte_idx_q <= '0;  // fresh count per packet
    end else if (rd_en_o) begin
      byte_idx_q <= byte_idx_q + 1'b1;
    end
  end

endmodule

//--- src/status_ctrl.sv
`timescale 1ns/1ps

module status_ctrl (
  input  logic                               ulpi_clk,
  input  logic                               I_rst_n,
  input  logic                               frame_start_i,    // vsync rise
  input  logic                               pixel_written_i,
  input  logic                               pixel_dropped_i,
  input  logic                               usb_online_i,     // controller enumerated
  output logic [status_pkg::FRAME_CNT_W-1:0] frame_pixels_o,   // last frame's total
  output logic [status_pkg::FRAME_CNT_W-1:0] drop_count_o,     // running drops
  output logic                               overflow_o,       // any drop so far
  output logic [status_pkg::LED_W-1:0]       led_o
);

  logic [status_pkg::FRAME_CNT_W-1:0] pix_cnt_q;  // current frame so far
  logic                               run_q;      // set once reset is released

  // ====================
  // frame accounting
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      pix_cnt_q      <= '0;
      frame_pixels_o <= '0;
    end else if (frame_start_i) begin
      frame_pixels_o <= pix_cnt_q;  // snapshot ended frame
      // a pixel on the start cycle belongs to the new frame
      pix_cnt_q      <= {{(status_pkg::FRAME_CNT_W-1){1'b0}}, pixel_written_i};
    end else if (pixel_written_i) begin
      pix_cnt_q <= pix_cnt_q + 1'b1;
    end
  end

  // drops and sticky flag
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      drop_count_o <= '0;
      overflow_o   <= 1'b0;
      run_q        <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (pixel_dropped_i) begin
        drop_count_o <= drop_count_o + 1'b1;
        overflow_o   <= 1'b1;  // only reset clears it
      end
    end
  end

  // ====================
  // leds, active low
  assign led_o[status_pkg::LED_ONLINE] = usb_online_i ? status_pkg::LED_ON : status_pkg::LED_OFF;
  assign led_o[status_pkg::LED_OVF]    = overflow_o ? status_pkg::LED_ON : status_pkg::LED_OFF;
  assign led_o[status_pkg::LED_SPARE]  = status_pkg::LED_OFF;
  assign led_o[status_pkg::LED_RUN]    = run_q ? status_pkg::LED_ON : status_pkg::LED_OFF;

endmodule

//--- src/cam_usb_top.sv
`timescale 1ns/1ps

module cam_usb_top (
  input  logic                               ulpi_clk,
  input  logic                               I_rst_n,
  // camera
  input  logic                               cam_vsync_i,
  input  logic                               cam_de_i,
  input  logic [stream_pkg::PIXEL_W-1:0]     cam_data_i,
  // usb device controller
  input  logic                               usb_online_i,
  input  logic                               usb_txpop_i,
  output logic [stream_pkg::BYTE_W-1:0]      usb_txdat_o,
  output logic                               usb_txval_o,
  output logic                               usb_txcork_o,
  output logic [stream_pkg::LEN_W-1:0]       usb_txdat_len_o,
  output logic                               usb_pkt_done_o,
  // status
  output logic [status_pkg::FRAME_CNT_W-1:0] frame_pixels_o,
  output logic [status_pkg::FRAME_CNT_W-1:0] drop_count_o,
  output logic                               overflow_o,
  output logic [status_pkg::LED_W-1:0]       led_o
);

  // ====================
  // internal nets
  logic                           wr_en;          // decode -> fifo
  logic [stream_pkg::PIXEL_W-1:0] wr_data;
  logic                           almost_full;    // fifo -> decode
  logic [stream_pkg::CNT_W-1:0]   byte_count;     // fifo -> tx
  logic [stream_pkg::BYTE_W-1:0]  head_byte;
  logic                           rd_en;          // tx -> fifo
  logic                           frame_start;    // decode -> status
  logic                           pixel_written;
  logic                           pixel_dropped;

  pixel_decode u_decode (
    .ulpi_clk           (ulpi_clk),
    .I_rst_n            (I_rst_n),
    .cam_vsync_i        (cam_vsync_i),
    .cam_de_i           (cam_de_i),
    .cam_data_i         (cam_data_i),
    .fifo_almost_full_i (almost_full),
    .wr_en_o            (wr_en),
    .wr_data_o          (wr_data),
    .frame_start_o      (frame_start),
    .pixel_written_o    (pixel_written),
    .pixel_dropped_o    (pixel_dropped)
  );

  byte_fifo u_fifo (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .wr_en_i       (wr_en),
    .wr_data_i     (wr_data),
    .rd_en_i       (rd_en),
    .almost_full_o (almost_full),
    .byte_count_o  (byte_count),
    .head_byte_o   (head_byte)
  );

  packet_tx u_tx (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .byte_count_i (byte_count),
    .head_byte_i  (head_byte),
    .txpop_i      (usb_txpop_i),
    .rd_en_o      (rd_en),
    .txdat_o      (usb_txdat_o),
    .txval_o      (usb_txval_o),
    .txcork_o     (usb_txcork_o),
    .txdat_len_o  (usb_txdat_len_o),
    .pkt_done_o   (usb_pkt_done_o)
  );

  status_ctrl u_status (
    .ulpi_clk        (ulpi_clk),
    .I_rst_n         (I_rst_n),
    .frame_start_i   (frame_start),
    .pixel_written_i (pixel_written),
    .pixel_dropped_i (pixel_dropped),
    .usb_online_i    (usb_online_i),
    .frame_pixels_o  (frame_pixels_o),
    .drop_count_o    (drop_count_o),
    .overflow_o      (overflow_o),
    .led_o           (led_o)
  );

endmodule

//--- verification/tb_cam_usb_top.sv
`timescale 1ns/1ps

module tb_cam_usb_top;

  typedef logic [stream_pkg::BYTE_W-1:0]       byte_t;
  typedef logic [stream_pkg::PIXEL_W-1:0]      pixel_t;
  typedef logic [stream_pkg::LEN_W-1:0]        len_t;
  typedef logic [status_pkg::FRAME_CNT_W-1:0]  count_t;
  typedef enum int {POP_ALL, POP_GAPS, POP_NONE} pop_mode_e;

  typedef struct {
    int        pixels;     // pixels streamed in the frame
    pop_mode_e mode;       // host behaviour after the frame
    int        packets;    // packets popped after the frame
    int        frame_pix;  // accepted pixels, seen at next vsync
    int        drops;      // pixels lost in this frame
  } frame_row_t;

  logic   ulpi_clk = 1'b0;
  logic   I_rst_n;
  logic   cam_vsync_i;
  logic   cam_de_i;
  pixel_t cam_data_i;
  logic   usb_online_i;
  logic   usb_txpop_i;
  byte_t  usb_txdat_o;
  logic   usb_txval_o;
  logic   usb_txcork_o;
  logic   usb_pkt_done_o;
  logic   overflow_o;
  count_t frame_pixels_o;
  count_t drop_count_o;
  len_t   usb_txdat_len_o;
  logic [status_pkg::LED_W-1:0] led_o;

  frame_row_t rows [7];
  byte_t      model_q [$];  // bytes the host should see, in order
  int errors = 0;
  int tests = 0;
  int failed = 0;
  int drop_total = 0;
  int prev_pix = 0;         // accepted count of the frame before
  int errs;
  bit timed_out = 1'b0;

  always #2 ulpi_clk = ~ulpi_clk;  // 4 ns period

  cam_usb_top u_dut (.*);

  // ====================
  // compare tasks
  task automatic check_byte(string name, byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(string name, count_t got, count_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%04h expected 0x%04h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_len(string name, len_t got, len_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%03h expected 0x%03h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_state(stream_pkg::tx_state_e exp);
    logic exp_val;
    exp_val = (exp == stream_pkg::TX_SEND);               // valid only while sending
    check_flag("usb_txval_o", usb_txval_o, exp_val);
    check_flag("usb_txcork_o", usb_txcork_o, !exp_val);   // idle here means starved
  endtask

  task automatic end_test(string name, int errs_at_start);
    tests++;
    if (errors != errs_at_start) begin
      failed++;
      $display("test %-14s FAIL (%0d errors)", name, errors - errs_at_start);
    end else begin
      $display("test %-14s pass", name);
    end
  endtask

  // ====================
  // model
  // usb side order is red, green, blue from the top bit down
  function automatic pixel_t reorder_rgb(pixel_t cam);
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    red   = cam[4:0];     // camera low field
    green = cam[10:5];
    blue  = cam[15:11];   // camera top field
    return {red, green, blue};
  endfunction

  // ====================
  // stimulus tasks
  // frame_pixels_o updates two edges after vsync is driven high
  task automatic pulse_vsync(int exp_pix);
    @(posedge ulpi_clk);
    cam_vsync_i <= 1'b1;
    repeat (3) @(posedge ulpi_clk);
    cam_vsync_i <= 1'b0;
    @(negedge ulpi_clk);
    check_count("frame_pixels_o", frame_pixels_o, count_t'(exp_pix));
  endtask

  task automatic send_frame(int n);
    pixel_t pix;
    for (int i = 0; i < n; i++) begin
      @(posedge ulpi_clk);
      pix = pixel_t'($urandom);
      cam_de_i   <= 1'b1;
      cam_data_i <= pix;
      if (model_q.size() + 2 <= stream_pkg::FIFO_BYTES - 2) begin  // 2 bytes must stay free
        pix = reorder_rgb(pix);
        model_q.push_back(pix[15:8]);             // high byte leaves first
        model_q.push_back(pix[7:0]);
      end
    end
    @(posedge ulpi_clk);
    cam_de_i <= 1'b0;
    repeat (3) @(posedge ulpi_clk);  // decode + fifo + status pipeline
    @(negedge ulpi_clk);
  endtask

  task automatic idle_pops_ignored();
    for (int i = 0; i < 8; i++) begin
      @(posedge ulpi_clk);
      usb_txpop_i <= 1'b1;
      @(negedge ulpi_clk);
      check_state(stream_pkg::TX_IDLE);
    end
    @(posedge ulpi_clk);
    usb_txpop_i <= 1'b0;
  endtask

  task automatic pop_packet(bit gaps);
    int wait_cyc;
    wait_cyc = 0;
    @(negedge ulpi_clk);
    while (usb_txval_o !== 1'b1 && wait_cyc < 50) begin
      @(negedge ulpi_clk);
      wait_cyc++;
    end
    if (usb_txval_o !== 1'b1) begin
      $display("timeout: no packet offered within 50 cycles, %0d bytes buffered",
               model_q.size());
      timed_out = 1'b1;
      errors++;
    end else begin
      check_state(stream_pkg::TX_SEND);
      check_len("usb_txdat_len_o", usb_txdat_len_o, len_t'(stream_pkg::PKT_BYTES));
      for (int b = 0; b < stream_pkg::PKT_BYTES; b++) begin
        if (gaps) begin
          repeat ($urandom_range(3, 0)) begin  // host stalls
            @(posedge ulpi_clk);
            usb_txpop_i <= 1'b0;
          end
        end
        @(posedge ulpi_clk);
        usb_txpop_i <= 1'b1;
        @(negedge ulpi_clk);
        check_flag("usb_txval_o", usb_txval_o, 1'b1);
        check_byte("usb_txdat_o", usb_txdat_o, model_q.pop_front());
        check_flag("usb_pkt_done_o", usb_pkt_done_o, b == stream_pkg::PKT_BYTES - 1);
      end
      @(posedge ulpi_clk);
      usb_txpop_i <= 1'b0;
    end
  endtask

  // ====================
  // main sequence
  initial begin
    void'($urandom(32'hb02b_f2b0));
    I_rst_n      = 1'b0;
    cam_vsync_i  = 1'b0;
    cam_de_i     = 1'b0;
    cam_data_i   = '0;
    usb_online_i = 1'b0;
    usb_txpop_i  = 1'b0;
    rows[0] = '{100, POP_ALL,  0, 100, 0};   // below threshold, pops ignored
    rows[1] = '{300, POP_ALL,  1, 300, 0};
    rows[2] = '{352, POP_GAPS, 1, 352, 0};
    rows[3] = '{16,  POP_GAPS, 1, 16,  0};   // lands on exactly 512 bytes
    rows[4] = '{600, POP_NONE, 0, 511, 89};  // overflow from empty
    rows[5] = '{0,   POP_ALL,  1, 0,   0};
    rows[6] = '{1,   POP_GAPS, 1, 1,   0};   // drains the remainder
    repeat (10) @(posedge ulpi_clk);
    I_rst_n <= 1'b1;
    @(posedge ulpi_clk);
    @(negedge ulpi_clk);
    check_state(stream_pkg::TX_IDLE);
    check_flag("usb_pkt_done_o", usb_pkt_done_o, 1'b0);
    check_len("usb_txdat_len_o", usb_txdat_len_o, len_t'(stream_pkg::PKT_BYTES));
    check_count("frame_pixels_o", frame_pixels_o, '0);
    check_count("drop_count_o", drop_count_o, '0);
    check_flag("overflow_o", overflow_o, 1'b0);
    check_flag("led_o[2]", led_o[2], ~status_pkg::LED_ON);  // spare stays dark
    check_flag("led_o[3]", led_o[3], status_pkg::LED_ON);   // out of reset
    end_test("reset", 0);

    for (int r = 0; r < 7 && !timed_out; r++) begin
      errs = errors;
      @(posedge ulpi_clk);
      usb_online_i <= r[0];
      pulse_vsync(prev_pix);
      check_flag("led_o[0]", led_o[0], r[0] ? status_pkg::LED_ON : ~status_pkg::LED_ON);
      send_frame(rows[r].pixels);
      drop_total += rows[r].drops;
      check_count("drop_count_o", drop_count_o, count_t'(drop_total));
      check_flag("overflow_o", overflow_o, drop_total != 0);
      check_flag("led_o[1]", led_o[1],
                 (drop_total != 0) ? status_pkg::LED_ON : ~status_pkg::LED_ON);
      if (model_q.size() < stream_pkg::PKT_BYTES) begin
        idle_pops_ignored();
      end
      for (int p = 0; p < rows[r].packets && !timed_out; p++) begin
        pop_packet(rows[r].mode == POP_GAPS);
      end
      @(posedge ulpi_clk);
      @(negedge ulpi_clk);
      check_state(model_q.size() < stream_pkg::PKT_BYTES ? stream_pkg::TX_IDLE
                                                          : stream_pkg::TX_SEND);
      prev_pix = rows[r].frame_pix;
      end_test($sformatf("frame %0d", r), errs);
    end

    if (!timed_out) begin
      errs = errors;
      pulse_vsync(prev_pix);  // closes the last frame
      end_test("last count", errs);
    end

    $display("tests %0d, failed %0d, check errors %0d", tests, failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- flist.f
src/stream_pkg.sv
src/status_pkg.sv
src/pixel_decode.sv
src/byte_fifo.sv
src/packet_tx.sv
src/status_ctrl.sv
src/cam_usb_top.sv
verification/tb_cam_usb_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_cam_usb_top \
  -Mdir "$OBJ_DIR" \
  -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_cam_usb_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "result: FAIL"
  exit 1
fi
echo "result: PASS"
exit 0
